// File: logic/mem_geometry_pkg.sv
package mem_geometry_pkg;

    // External bus widths
    localparam int ADDR_BUS_WIDTH = 64;  // RV64 address bus
    localparam int DWORD_WIDTH    = 64;

    // Storage shape
    localparam int BYTE_WIDTH = 8;  // One stored element
    localparam int LANES      = DWORD_WIDTH / BYTE_WIDTH;  // Bytes per block

    typedef logic [ADDR_BUS_WIDTH-1:0] addr_bus_t;
    typedef logic [DWORD_WIDTH-1:0]    dword_t;
    typedef logic [BYTE_WIDTH-1:0]     mem_byte_t;

    // One enable bit per byte lane of a block
    typedef logic [LANES-1:0] lane_mask_t;

endpackage

// File: logic/mem_access_pkg.sv
package mem_access_pkg;

    // Access size on both ports, code 3 means no access
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } access_size_t;

    // Write control
    typedef enum logic {
        WR_IDLE   = 1'b0,
        WR_COMMIT = 1'b1
    } wr_state_t;

    // Word needs 4-byte alignment, doubleword needs 8-byte alignment
    function automatic logic is_misaligned(access_size_t size, logic [2:0] low_bits);
        case (size)
            SIZE_DWORD: return low_bits != 3'b000;
            SIZE_WORD:  return low_bits[1:0] != 2'b00;
            default:    return 1'b0;  // Bytes are always aligned
        endcase
    endfunction

endpackage

// File: logic/wr_capture.sv
module wr_capture
    import mem_geometry_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int ADDR_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_ins_i,
    input  addr_bus_t                     wr_addr_i,
    input  access_size_t                  wr_size_i,
    input  dword_t                        wr_data_i,
    output logic [$clog2(ADDR_DEPTH)-1:0] buf_addr_o,
    output access_size_t                  buf_size_o,
    output dword_t                        buf_data_o,
    output logic                          commit_o,
    output logic                          wr_idle_o,
    output logic                          wr_invalid_o
);

    localparam int AW = $clog2(ADDR_DEPTH);

    wr_state_t     state_q;
    wr_state_t     state_d;
    logic [AW-1:0] addr_q;
    access_size_t  size_q;
    dword_t        data_q;
    logic          commit_q;
    logic          capture;
    logic          misaligned;

    // Request is taken only while idle, anything else is dropped
    assign capture    = (state_q == WR_IDLE) && wr_ins_i;
    assign misaligned = is_misaligned(size_q, addr_q[2:0]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (capture) begin
                    state_d = WR_COMMIT;
                end
            end
            WR_COMMIT: state_d = WR_IDLE;  // Single commit cycle
            default:   state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= WR_IDLE;
            commit_q <= 1'b0;
            addr_q   <= '0;
            size_q   <= SIZE_BYTE;
            data_q   <= '0;
        end else begin
            state_q  <= state_d;
            commit_q <= (state_q == WR_COMMIT) && !misaligned;  // Misaligned never reaches array
            if (capture) begin
                addr_q <= wr_addr_i[AW-1:0];  // Upper bus bits wrap
                size_q <= wr_size_i;
                data_q <= wr_data_i;
            end
        end
    end

    assign buf_addr_o   = addr_q;
    assign buf_size_o   = size_q;
    assign buf_data_o   = data_q;
    assign commit_o     = commit_q;
    assign wr_idle_o    = (state_q == WR_IDLE);
    assign wr_invalid_o = misaligned;  // Holds until next capture

    // Strobe only follows a commit cycle
    commit_after_commit_state: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_o |-> $past(state_q) == WR_COMMIT
    ) else $error("commit strobe without a preceding commit cycle");

    // One write per captured request
    commit_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_o |=> !commit_o
    ) else $error("commit strobe held for two cycles");

endmodule

// File: logic/wr_lane_steer.sv
module wr_lane_steer
    import mem_geometry_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int ADDR_DEPTH = 1024
) (
    input  logic [$clog2(ADDR_DEPTH)-1:0]   buf_addr_i,
    input  access_size_t                    buf_size_i,
    input  dword_t                          buf_data_i,
    input  logic                            commit_i,
    output logic [$clog2(ADDR_DEPTH)-4:0]   blk_idx_o,
    output lane_mask_t                      lane_en_o,
    output mem_byte_t [LANES-1:0]           lane_data_o
);

    localparam int AW         = $clog2(ADDR_DEPTH);
    localparam int WORD_BYTES = 4;

    lane_mask_t lane_sel;

    assign blk_idx_o = buf_addr_i[AW-1:3];  // Doubleword block

    // Lanes touched by the access
    always_comb begin
        case (buf_size_i)
            SIZE_DWORD: lane_sel = '1;
            SIZE_WORD:  lane_sel = buf_addr_i[2] ? 8'hF0 : 8'h0F;  // Upper or lower half
            SIZE_BYTE:  lane_sel = lane_mask_t'(1) << buf_addr_i[2:0];
            default:    lane_sel = '0;
        endcase
    end

    // Nothing is written outside the commit cycle
    assign lane_en_o = commit_i ? lane_sel : '0;

    // Little-endian routing of data bytes into lanes
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            case (buf_size_i)
                SIZE_DWORD: lane_data_o[l] = buf_data_i[l*BYTE_WIDTH +: BYTE_WIDTH];
                SIZE_WORD: begin
                    // Same four bytes land in either half
                    lane_data_o[l] = buf_data_i[(l % WORD_BYTES)*BYTE_WIDTH +: BYTE_WIDTH];
                end
                default:    lane_data_o[l] = buf_data_i[BYTE_WIDTH-1:0];  // Byte copied to all
            endcase
        end
    end

endmodule

// File: logic/byte_array.sv
module byte_array
    import mem_geometry_pkg::*;
#(
    parameter int ADDR_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [$clog2(ADDR_DEPTH)-4:0] wr_blk_i,
    input  lane_mask_t                    lane_en_i,
    input  mem_byte_t [LANES-1:0]         lane_data_i,
    input  logic [$clog2(ADDR_DEPTH)-4:0] rd_blk_i,
    output dword_t                        rd_block_o
);

    localparam int BLOCKS = ADDR_DEPTH / LANES;

    // Lane 0 holds the lowest address of each block
    mem_byte_t [LANES-1:0] mem_q [BLOCKS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < BLOCKS; b++) begin
                mem_q[b] <= '0;  // All bytes come up zero
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (lane_en_i[l]) begin
                    mem_q[wr_blk_i][l] <= lane_data_i[l];
                end
            end
        end
    end

    // Lowest address ends up in the low byte
    assign rd_block_o = mem_q[rd_blk_i];

    // Steering only ever produces these lane shapes
    lane_shape_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(lane_en_i) || (lane_en_i inside {8'hFF, 8'h0F, 8'hF0})
    ) else $error("illegal lane enable pattern %b", lane_en_i);

endmodule

// File: logic/rd_align.sv
module rd_align
    import mem_geometry_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int ADDR_DEPTH = 1024
) (
    input  logic                          rd_en_i,
    input  addr_bus_t                     rd_addr_i,
    input  access_size_t                  rd_size_i,
    input  dword_t                        rd_block_i,
    output logic [$clog2(ADDR_DEPTH)-4:0] rd_blk_o,
    output dword_t                        rd_data_o,
    output logic                          rd_invalid_o
);

    localparam int AW         = $clog2(ADDR_DEPTH);
    localparam int WORD_WIDTH = 4 * BYTE_WIDTH;

    logic [AW-1:0] addr_int;
    access_size_t  size_int;

    // Disabled port falls back to a byte read at address 0
    assign addr_int = rd_en_i ? rd_addr_i[AW-1:0] : '0;
    assign size_int = rd_en_i ? rd_size_i : SIZE_BYTE;

    assign rd_blk_o     = addr_int[AW-1:3];
    assign rd_invalid_o = is_misaligned(size_int, addr_int[2:0]);

    // Misaligned accesses return the aligned-down unit
    always_comb begin
        case (size_int)
            SIZE_DWORD: rd_data_o = rd_block_i;
            SIZE_WORD: begin
                rd_data_o = dword_t'(rd_block_i[addr_int[2]*WORD_WIDTH +: WORD_WIDTH]);
            end
            SIZE_BYTE: begin
                rd_data_o = dword_t'(rd_block_i[addr_int[2:0]*BYTE_WIDTH +: BYTE_WIDTH]);
            end
            default:    rd_data_o = '0;  // No access
        endcase
    end

    // Flag only on an enabled word or doubleword read
    always_comb begin
        if (rd_invalid_o) begin
            rd_invalid_size: assert final (rd_en_i && (size_int inside {SIZE_WORD, SIZE_DWORD}))
                else $error("read flag raised for size %0d", size_int);
        end
    end

endmodule

// File: logic/data_mem_top.sv
module data_mem_top
    import mem_geometry_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int ADDR_DEPTH = 1024  // Bytes, power of two, at least 16
) (
    input  logic         clk,
    input  logic         rst_n,
    // Write port
    input  logic         wr_ins_i,
    input  addr_bus_t    wr_addr_i,
    input  access_size_t wr_size_i,
    input  dword_t       wr_data_i,
    output logic         wr_idle_o,
    output logic         wr_invalid_o,
    // Read port
    input  logic         rd_en_i,
    input  addr_bus_t    rd_addr_i,
    input  access_size_t rd_size_i,
    output dword_t       rd_data_o,
    output logic         rd_invalid_o
);

    localparam int AW = $clog2(ADDR_DEPTH);

    logic [AW-1:0]         buf_addr;
    access_size_t          buf_size;
    dword_t                buf_data;
    logic                  commit;
    logic [AW-4:0]         wr_blk;
    lane_mask_t            lane_en;
    mem_byte_t [LANES-1:0] lane_data;
    logic [AW-4:0]         rd_blk;
    dword_t                rd_block;

    wr_capture #(
        .ADDR_DEPTH(ADDR_DEPTH)
    ) i_wr_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_ins_i    (wr_ins_i),
        .wr_addr_i   (wr_addr_i),
        .wr_size_i   (wr_size_i),
        .wr_data_i   (wr_data_i),
        .buf_addr_o  (buf_addr),
        .buf_size_o  (buf_size),
        .buf_data_o  (buf_data),
        .commit_o    (commit),
        .wr_idle_o   (wr_idle_o),
        .wr_invalid_o(wr_invalid_o)
    );

    wr_lane_steer #(
        .ADDR_DEPTH(ADDR_DEPTH)
    ) i_wr_lane_steer (
        .buf_addr_i (buf_addr),
        .buf_size_i (buf_size),
        .buf_data_i (buf_data),
        .commit_i   (commit),
        .blk_idx_o  (wr_blk),
        .lane_en_o  (lane_en),
        .lane_data_o(lane_data)
    );

    byte_array #(
        .ADDR_DEPTH(ADDR_DEPTH)
    ) i_byte_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_blk_i   (wr_blk),
        .lane_en_i  (lane_en),
        .lane_data_i(lane_data),
        .rd_blk_i   (rd_blk),
        .rd_block_o (rd_block)
    );

    // Combinational read, same cycle as the address
    rd_align #(
        .ADDR_DEPTH(ADDR_DEPTH)
    ) i_rd_align (
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_size_i   (rd_size_i),
        .rd_block_i  (rd_block),
        .rd_blk_o    (rd_blk),
        .rd_data_o   (rd_data_o),
        .rd_invalid_o(rd_invalid_o)
    );

endmodule

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row kinds: a read, a single write strobe, or a strobe held into the busy cycle
typedef enum logic [1:0] {
    OP_READ        = 2'd0,
    OP_WRITE       = 2'd1,
    OP_WRITE_TWICE = 2'd2
} tb_op_t;

// Columns: test number, op, address, size, write data, rd_en, expected data, expected flag
// For writes the flag column is wr_invalid_o and the expected data is unused
typedef struct packed {
    int           num;
    tb_op_t       op;
    addr_bus_t    addr;
    access_size_t size;
    dword_t       data;
    logic         rd_en;
    dword_t       exp_data;
    logic         exp_flag;
} vec_t;

vec_t vectors[$];

task automatic add_row(tb_op_t op, addr_bus_t addr, access_size_t size, dword_t data,
                       logic rd_en, dword_t exp_data, logic exp_flag);
    vec_t v;
    v.num      = vectors.size() + 1;
    v.op       = op;
    v.addr     = addr;
    v.size     = size;
    v.data     = data;
    v.rd_en    = rd_en;
    v.exp_data = exp_data;
    v.exp_flag = exp_flag;
    vectors.push_back(v);
endtask

task automatic load_vectors();
    // Fresh array reads as zero
    add_row(OP_READ,  64'h0000_0000_0000_0000, SIZE_DWORD, 64'h0, 1'b1, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0008, SIZE_DWORD, 64'h0, 1'b1, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_03F8, SIZE_DWORD, 64'h0, 1'b1, 64'h0, 1'b0);
    // Little-endian layout and zero extension
    add_row(OP_WRITE, 64'h0000_0000_0000_0010, SIZE_DWORD, 64'h8877_6655_4433_2211, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0010, SIZE_BYTE,  64'h0, 1'b1, 64'h11, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0013, SIZE_BYTE,  64'h0, 1'b1, 64'h44, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0017, SIZE_BYTE,  64'h0, 1'b1, 64'h88, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0010, SIZE_WORD,  64'h0, 1'b1, 64'h4433_2211, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0014, SIZE_WORD,  64'h0, 1'b1, 64'h8877_6655, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0010, SIZE_DWORD, 64'h0, 1'b1, 64'h8877_6655_4433_2211, 1'b0);
    // Narrow writes merge into an existing block
    add_row(OP_WRITE, 64'h0000_0000_0000_0020, SIZE_DWORD, 64'h0706_0504_0302_0100, 1'b0, 64'h0, 1'b0);
    add_row(OP_WRITE, 64'h0000_0000_0000_0022, SIZE_BYTE,  64'hFFFF_FFFF_FFFF_FFAB, 1'b0, 64'h0, 1'b0);
    add_row(OP_WRITE, 64'h0000_0000_0000_0024, SIZE_WORD,  64'h1111_1111_DEAD_BEEF, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0020, SIZE_DWORD, 64'h0, 1'b1, 64'hDEAD_BEEF_03AB_0100, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0020, SIZE_WORD,  64'h0, 1'b1, 64'h03AB_0100, 1'b0);
    // Misaligned writes are flagged and dropped
    add_row(OP_WRITE, 64'h0000_0000_0000_0012, SIZE_WORD,  64'h0000_0000_AAAA_AAAA, 1'b0, 64'h0, 1'b1);
    add_row(OP_READ,  64'h0000_0000_0000_0010, SIZE_DWORD, 64'h0, 1'b1, 64'h8877_6655_4433_2211, 1'b0);
    add_row(OP_WRITE, 64'h0000_0000_0000_0019, SIZE_DWORD, 64'hBBBB_BBBB_BBBB_BBBB, 1'b0, 64'h0, 1'b1);
    add_row(OP_READ,  64'h0000_0000_0000_0018, SIZE_DWORD, 64'h0, 1'b1, 64'h0, 1'b0);
    add_row(OP_WRITE, 64'h0000_0000_0000_0030, SIZE_BYTE,  64'h0000_0000_0000_005A, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0030, SIZE_DWORD, 64'h0, 1'b1, 64'h5A, 1'b0);
    // Misaligned reads return the aligned-down unit
    add_row(OP_READ,  64'h0000_0000_0000_0012, SIZE_WORD,  64'h0, 1'b1, 64'h4433_2211, 1'b1);
    add_row(OP_READ,  64'h0000_0000_0000_0016, SIZE_WORD,  64'h0, 1'b1, 64'h8877_6655, 1'b1);
    add_row(OP_READ,  64'h0000_0000_0000_0013, SIZE_DWORD, 64'h0, 1'b1, 64'h8877_6655_4433_2211, 1'b1);
    add_row(OP_READ,  64'h0000_0000_0000_0015, SIZE_BYTE,  64'h0, 1'b1, 64'h66, 1'b0);
    // Disabled port reads byte 0
    add_row(OP_WRITE, 64'h0000_0000_0000_0000, SIZE_BYTE,  64'h0000_0000_0000_003C, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0017, SIZE_DWORD, 64'h0, 1'b0, 64'h3C, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0013, SIZE_WORD,  64'h0, 1'b0, 64'h3C, 1'b0);
    // Strobe during the busy cycle, then address wrap
    add_row(OP_WRITE_TWICE, 64'h0000_0000_0000_0040, SIZE_DWORD, 64'h0123_4567_89AB_CDEF,
            1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0040, SIZE_DWORD, 64'h0, 1'b1, 64'h0123_4567_89AB_CDEF, 1'b0);
    add_row(OP_WRITE, 64'hFFFF_0000_0000_0048, SIZE_DWORD, 64'h1234_5678_9ABC_DEF0, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_0048, SIZE_DWORD, 64'h0, 1'b1, 64'h1234_5678_9ABC_DEF0, 1'b0);
    add_row(OP_READ,  64'h8000_0000_0000_004C, SIZE_WORD,  64'h0, 1'b1, 64'h1234_5678, 1'b0);
    add_row(OP_WRITE, 64'h0000_0001_0000_03F8, SIZE_DWORD, 64'hFEDC_BA98_7654_3210, 1'b0, 64'h0, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_03F8, SIZE_DWORD, 64'h0, 1'b1, 64'hFEDC_BA98_7654_3210, 1'b0);
    add_row(OP_READ,  64'h0000_0000_0000_03FF, SIZE_BYTE,  64'h0, 1'b1, 64'hFE, 1'b0);
endtask

`endif

// File: testbench/tb_data_mem.sv
module tb_data_mem
    import mem_geometry_pkg::*;
    import mem_access_pkg::*;
();

    localparam int WAIT_LIMIT = 10;  // Cycles allowed for wr_idle_o to return

    logic         clk = 1'b0;
    logic         rst_n;
    logic         wr_ins_i;
    addr_bus_t    wr_addr_i;
    access_size_t wr_size_i;
    dword_t       wr_data_i;
    logic         wr_idle_o;
    logic         wr_invalid_o;
    logic         rd_en_i;
    addr_bus_t    rd_addr_i;
    access_size_t rd_size_i;
    dword_t       rd_data_o;
    logic         rd_invalid_o;

    int   test_errors;
    int   error_count;
    int   tests_run;
    int   tests_failed;
    logic timed_out;

    `include "tb_vectors.svh"

    data_mem_top #(
        .ADDR_DEPTH(1024)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_ins_i    (wr_ins_i),
        .wr_addr_i   (wr_addr_i),
        .wr_size_i   (wr_size_i),
        .wr_data_i   (wr_data_i),
        .wr_idle_o   (wr_idle_o),
        .wr_invalid_o(wr_invalid_o),
        .rd_en_i     (rd_en_i),
        .rd_addr_i   (rd_addr_i),
        .rd_size_i   (rd_size_i),
        .rd_data_o   (rd_data_o),
        .rd_invalid_o(rd_invalid_o)
    );

    always #50 clk = ~clk;

    task automatic check_value(string name, dword_t actual, dword_t expected);
        assert (actual === expected) else begin
            $display("Error %0t: %s = %h, expected %h", $time, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        assert (actual === expected) else begin
            $display("Error %0t: %s = %b, expected %b", $time, name, actual, expected);
            test_errors++;
        end
    endtask

    // Strobe one request, then wait for the port to go idle again
    task automatic apply_write(vec_t v);
        int busy;
        wr_addr_i = v.addr;
        wr_size_i = v.size;
        wr_data_i = v.data;
        wr_ins_i  = 1'b1;
        @(negedge clk);
        if (v.op == OP_WRITE_TWICE) begin
            wr_data_i = ~v.data;  // Must never reach the array
        end else begin
            wr_ins_i = 1'b0;
        end
        busy = 0;
        while (!wr_idle_o && !timed_out) begin
            busy++;
            @(negedge clk);
            wr_ins_i = 1'b0;
            if (!wr_idle_o && busy >= WAIT_LIMIT) begin
                $display("Timeout at %0t: wr_idle_o stayed low for %0d cycles", $time, busy);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            assert (busy == 1) else begin
                $display("Error %0t: wr_idle_o low for %0d cycles, expected 1", $time, busy);
                test_errors++;
            end
            check_flag("wr_invalid_o", wr_invalid_o, v.exp_flag);
        end
    endtask

    task automatic apply_read(vec_t v);
        rd_en_i   = v.rd_en;
        rd_addr_i = v.addr;
        rd_size_i = v.size;
        @(negedge clk);
        check_value("rd_data_o", rd_data_o, v.exp_data);
        check_flag("rd_invalid_o", rd_invalid_o, v.exp_flag);
    endtask

    task automatic report_test(int num, string kind);
        if (timed_out) begin
            test_errors++;
        end
        tests_run++;
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %0d (%s): %0d errors", num, kind, test_errors);
        end else begin
            $display("test %0d (%s): ok", num, kind);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        wr_ins_i     = 1'b0;
        wr_addr_i    = '0;
        wr_size_i    = SIZE_BYTE;
        wr_data_i    = '0;
        rd_en_i      = 1'b0;
        rd_addr_i    = '0;
        rd_size_i    = SIZE_BYTE;
        test_errors  = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        load_vectors();

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Write port state straight out of reset
        check_flag("wr_idle_o", wr_idle_o, 1'b1);
        check_flag("wr_invalid_o", wr_invalid_o, 1'b0);
        report_test(0, "reset");

        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            test_errors = 0;
            if (vectors[i].op == OP_READ) begin
                apply_read(vectors[i]);
                report_test(vectors[i].num, "read");
            end else begin
                apply_write(vectors[i]);
                report_test(vectors[i].num, "write");
            end
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: data_mem.f
+incdir+include
logic/mem_geometry_pkg.sv
logic/mem_access_pkg.sv
logic/wr_capture.sv
logic/wr_lane_steer.sv
logic/byte_array.sv
logic/rd_align.sv
logic/data_mem_top.sv
testbench/tb_data_mem.sv
